// File: hw/spiPkg.sv
// SPI block shared definitions: bus widths, register map and data types
`default_nettype none

package spiPkg;

	// ----------------------------------------
	// Bus and register widths
	// ----------------------------------------
	localparam int busAdrsBit   = 16;	// Register bus address
	localparam int busDataBit   = 32;	// Register bus data
	localparam int divBit       = 16;	// Divider register
	localparam int spiByteBit   = 8;	// One SPI transfer
	localparam int blockAdrsBit = 8;	// Upper address bits that pick the block
	localparam int regOfsBit    = busAdrsBit - blockAdrsBit;

	// Block select value in the upper address byte
	localparam logic [blockAdrsBit-1:0] blockAdrsMap = 8'h03;

	// ----------------------------------------
	// Register offsets, low address byte
	// ----------------------------------------
	localparam logic [regOfsBit-1:0] regCtrl   = 8'h00;	// [0] enable, [1] cs level
	localparam logic [regOfsBit-1:0] regDiv    = 8'h04;	// Half-period divider
	localparam logic [regOfsBit-1:0] regTxData = 8'h08;	// Write starts a byte
	localparam logic [regOfsBit-1:0] regRxData = 8'h0C;	// Last received byte
	localparam logic [regOfsBit-1:0] regStatus = 8'h10;	// [0] busy, [1] master mode

	// Control register bit positions
	localparam int ctrlEnBit = 0;
	localparam int ctrlCsBit = 1;

	// Status register bit positions
	localparam int statBusyBit   = 0;
	localparam int statMasterBit = 1;

	// ----------------------------------------
	// Slave mode bus writes
	// ----------------------------------------
	localparam logic [busAdrsBit-1:0] slaveWrBase = 16'h0100;	// First byte lands here

	// Shared types
	typedef logic [spiByteBit-1:0] spiByteT;	// SPI data
	typedef logic [busDataBit-1:0] usiDataT;	// Bus data
	typedef logic [busAdrsBit-1:0] usiAdrsT;	// Bus address
	typedef logic [divBit-1:0]     spiDivT;		// Divider value

endpackage

`default_nettype wire

// File: hw/spiClockGen.sv
// SPI master half-period tick generator from the programmable divider
`default_nettype none
`timescale 1ns/1ps

module spiClockGen (
	input  wire                  run,		// Count only during a transfer
	input  wire spiPkg::spiDivT  spiDiv,
	output logic                 halfTick,	// One cycle per SCK half-period
	input  wire                  sysClk,
	input  wire                  rstN
);

	import spiPkg::*;

	spiDivT divCnt;

	// ----------------------------------------
	// Divider counter
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			divCnt <= '0;
		else if (!run)
			divCnt <= '0;				// First half-period always full length
		else if (divCnt == spiDiv)
			divCnt <= '0;				// Wrap
		else
			divCnt <= divCnt + 1'b1;
	end

	// Tick on the last count of each half-period
	// so one half-period is spiDiv+1 cycles
	assign halfTick = run && (divCnt == spiDiv);

endmodule

`default_nettype wire

// File: hw/spiMasterEngine.sv
// SPI master byte engine, mode 0 and MSB first, with receive strobe
`default_nettype none
`timescale 1ns/1ps

module spiMasterEngine (
	input  wire                   spiEn,
	input  wire                   txStart,
	input  wire spiPkg::spiByteT  txData,
	input  wire                   halfTick,	// From the clock generator
	output logic                  run,		// Clock generator enable
	output logic                  sckOut,
	output logic                  mosiOut,
	input  wire                   misoIn,
	output spiPkg::spiByteT       rxByte,
	output logic                  rxValid,	// End of byte, also the interrupt
	output logic                  busy,
	input  wire                   sysClk,
	input  wire                   rstN
);

	import spiPkg::*;

	logic [3:0] halfCnt;	// 16 half-periods per byte
	logic       startOk;
	logic       lastHalf;
	spiByteT    txShift;
	spiByteT    rxShift;

	// Start only when enabled and idle, else dropped
	assign startOk  = txStart & spiEn & ~busy;
	assign lastHalf = (halfCnt == 4'd15);

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			busy    <= 1'b0;
			sckOut  <= 1'b0;	// SCK idles low
			rxValid <= 1'b0;
			halfCnt <= '0;
		end
		else
		begin
			rxValid <= 1'b0;
			if (startOk)
			begin
				busy    <= 1'b1;
				halfCnt <= '0;
				sckOut  <= 1'b0;
			end
			else if (busy && halfTick)
			begin
				halfCnt <= halfCnt + 1'b1;
				sckOut  <= ~halfCnt[0];	// Even count rises, odd count falls
				if (lastHalf)
				begin
					busy    <= 1'b0;	// SCK back low here
					rxValid <= 1'b1;
				end
			end
		end
	end

	// Transmit shifter drives the mosi pin, kept defined
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			txShift <= '0;
		else if (startOk)
			txShift <= txData;		// MSB out as busy rises
		else if (busy && halfTick && halfCnt[0])
			txShift <= {txShift[spiByteBit-2:0], 1'b0};	// Falling edge
	end

	// Sample miso on rising edges
	always_ff @(posedge sysClk)
	begin
		if (busy && halfTick && !halfCnt[0])
			rxShift <= {rxShift[spiByteBit-2:0], misoIn};
	end

	assign run     = busy;
	assign mosiOut = txShift[spiByteBit-1];
	assign rxByte  = rxShift;

endmodule

`default_nettype wire

// File: hw/spiSlaveEngine.sv
// SPI slave engine, pin synchronizer, byte assembly and bus writes
`default_nettype none
`timescale 1ns/1ps

module spiSlaveEngine (
	input  wire              sckIn,
	input  wire              mosiIn,
	input  wire              csIn,
	output logic             misoOut,
	output logic             misoEn,	// Drive miso only while selected
	output spiPkg::usiDataT  mUsiWd,
	output spiPkg::usiAdrsT  mUsiAdrs,
	output logic             mUsiWEd,	// One strobe per received byte
	output logic             mUsiMonopoly,
	input  wire              sysClk,
	input  wire              rstN
);

	import spiPkg::*;

	logic       sckS1, sckS2, sckS3;
	logic       mosiS1, mosiS2;
	logic       csS1, csS2, csS3;
	logic       sckRise, sckFall, csFall;
	logic [2:0] bitCnt;
	logic       byteDone;
	spiByteT    rxShift;
	spiByteT    lastByte;	// Echoed back on miso
	spiByteT    txShift;
	usiAdrsT    byteIdx;

	// ----------------------------------------
	// Pin synchronizer
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			{sckS1, sckS2, sckS3} <= '0;	// Idle low
			{mosiS1, mosiS2}      <= '0;
			{csS1, csS2, csS3}    <= '1;	// Deselected
		end
		else
		begin
			{sckS1, sckS2, sckS3} <= {sckIn, sckS1, sckS2};
			{mosiS1, mosiS2}      <= {mosiIn, mosiS1};
			{csS1, csS2, csS3}    <= {csIn, csS1, csS2};
		end
	end

	assign sckRise = sckS2 & ~sckS3;
	assign sckFall = ~sckS2 & sckS3;
	assign csFall  = ~csS2 & csS3;

	// ----------------------------------------
	// Bit count, bus strobe and miso shifter
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			bitCnt   <= '0;
			byteDone <= 1'b0;
			mUsiWEd  <= 1'b0;
			lastByte <= '0;		// Zero for the first byte
			txShift  <= '0;
			byteIdx  <= '0;
		end
		else
		begin
			byteDone <= 1'b0;
			mUsiWEd  <= byteDone;
			if (csS2)
				bitCnt <= '0;
			else if (sckRise)
			begin
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == 3'd7)
				begin
					lastByte <= {rxShift[spiByteBit-2:0], mosiS2};
					byteDone <= 1'b1;
				end
			end
			if (csFall)
				byteIdx <= '0;	// Index restarts per select
			else if (byteDone)
				byteIdx <= byteIdx + 1'b1;
			if (csFall)
				txShift <= lastByte;
			else if (sckFall && !csS2)
				txShift <= (bitCnt == 3'd0) ? lastByte
					: {txShift[spiByteBit-2:0], 1'b0};	// Reload between bytes
		end
	end

	// Payload path
	always_ff @(posedge sysClk)
	begin
		if (sckRise && !csS2)
			rxShift <= {rxShift[spiByteBit-2:0], mosiS2};	// MSB first
		if (byteDone)
		begin
			mUsiWd   <= usiDataT'(lastByte);	// Zero extended
			mUsiAdrs <= slaveWrBase + byteIdx;
		end
	end

	assign misoOut      = txShift[spiByteBit-1];
	assign misoEn       = ~csS2;
	assign mUsiMonopoly = ~csS2;	// Hold the bus while selected

endmodule

`default_nettype wire

// File: hw/spiUnit.sv
// SPI unit, latches master or slave mode and drives the tri-state pins
`default_nettype none
`timescale 1ns/1ps

module spiUnit (
	inout  wire                   spiSck,
	inout  wire                   spiMosi,
	inout  wire                   spiMiso,
	inout  wire                   spiCs,
	input  wire                   mSSel,	// High master, low slave
	// Control from the register file
	input  wire                   spiEn,
	input  wire                   masterCs,
	input  wire spiPkg::spiDivT   spiDiv,
	input  wire spiPkg::spiByteT  txData,
	input  wire                   txStart,
	// Status to the register file
	output spiPkg::spiByteT       rxData,
	output logic                  rxValid,
	output logic                  busy,
	output logic                  masterMode,
	// Register bus master side
	output spiPkg::usiDataT       mUsiWd,
	output spiPkg::usiAdrsT       mUsiAdrs,
	output logic                  mUsiWEd,
	output logic                  mUsiMonopoly,
	output logic                  spiIntr,
	input  wire                   sysClk,
	input  wire                   rstN
);

	logic modeDone;		// Mode sampled once
	logic masterRstN, slaveRstN;
	logic run, halfTick;
	logic sckOut, mosiOut;
	logic misoOut, misoEn;

	// ----------------------------------------
	// Mode latch
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			modeDone   <= 1'b0;
			masterMode <= 1'b0;
		end
		else if (!modeDone)
		begin
			modeDone   <= 1'b1;	// First edge out of reset
			masterMode <= mSSel;
		end
	end

	// Unused engine stays in reset
	assign masterRstN = rstN & modeDone & masterMode;
	assign slaveRstN  = rstN & modeDone & ~masterMode;

	spiClockGen u_spiClockGen (
		.run      (run),
		.spiDiv   (spiDiv),
		.halfTick (halfTick),
		.sysClk   (sysClk),
		.rstN     (masterRstN)
	);

	spiMasterEngine u_spiMasterEngine (
		.spiEn    (spiEn),
		.txStart  (txStart),
		.txData   (txData),
		.halfTick (halfTick),
		.run      (run),
		.sckOut   (sckOut),
		.mosiOut  (mosiOut),
		.misoIn   (spiMiso),
		.rxByte   (rxData),
		.rxValid  (rxValid),
		.busy     (busy),
		.sysClk   (sysClk),
		.rstN     (masterRstN)
	);

	spiSlaveEngine u_spiSlaveEngine (
		.sckIn        (spiSck),
		.mosiIn       (spiMosi),
		.csIn         (spiCs),
		.misoOut      (misoOut),
		.misoEn       (misoEn),
		.mUsiWd       (mUsiWd),
		.mUsiAdrs     (mUsiAdrs),
		.mUsiWEd      (mUsiWEd),
		.mUsiMonopoly (mUsiMonopoly),
		.sysClk       (sysClk),
		.rstN         (slaveRstN)
	);

	// ----------------------------------------
	// Pin drivers
	// ----------------------------------------
	assign spiSck  = masterMode ? sckOut   : 1'bz;
	assign spiMosi = masterMode ? mosiOut  : 1'bz;
	assign spiCs   = masterMode ? masterCs : 1'bz;
	assign spiMiso = misoEn     ? misoOut  : 1'bz;	// Slave only, under cs

	assign spiIntr = rxValid;	// Master byte done

endmodule

`default_nettype wire

// File: hw/spiCsr.sv
// SPI register file on the register bus slave side, control values and read-back
`default_nettype none
`timescale 1ns/1ps

module spiCsr (
	// Register bus slave side
	input  wire spiPkg::usiDataT  sUsiWd,
	input  wire spiPkg::usiAdrsT  sUsiAdrs,
	input  wire                   sUsiWCke,	// Write strobe
	input  wire                   sUsiRCke,	// Read strobe
	output spiPkg::usiDataT       sUsiRd,
	output logic                  sUsiREd,	// Read data valid, one cycle later
	// Control towards the SPI unit
	output logic                  spiEn,
	output logic                  masterCs,	// Chip select level in master mode
	output spiPkg::spiDivT        spiDiv,
	output spiPkg::spiByteT       txData,
	output logic                  txStart,	// One cycle per regTxData write
	// Status from the SPI unit
	input  wire spiPkg::spiByteT  rxData,
	input  wire                   rxValid,
	input  wire                   busy,
	input  wire                   masterMode,
	input  wire                   sysClk,
	input  wire                   rstN
);

	import spiPkg::*;

	logic                 blockHit;	// Upper byte matches this block
	logic [regOfsBit-1:0] regOfs;
	logic                 wrHit;
	spiByteT              rxReg;	// Latched received byte
	usiDataT              rdMux;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	assign blockHit = (sUsiAdrs[busAdrsBit-1 -: blockAdrsBit] == blockAdrsMap);
	assign regOfs   = sUsiAdrs[regOfsBit-1:0];
	assign wrHit    = sUsiWCke & blockHit;

	// Control registers
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			spiEn    <= 1'b0;
			masterCs <= 1'b1;	// Deselected
			spiDiv   <= '0;
			txStart  <= 1'b0;
			sUsiREd  <= 1'b0;
		end
		else
		begin
			txStart <= wrHit && (regOfs == regTxData);
			sUsiREd <= sUsiRCke & blockHit;	// Foreign block, no response
			if (wrHit && (regOfs == regCtrl))
			begin
				spiEn    <= sUsiWd[ctrlEnBit];
				masterCs <= sUsiWd[ctrlCsBit];
			end
			if (wrHit && (regOfs == regDiv))
				spiDiv <= sUsiWd[divBit-1:0];
		end
	end

	// Data registers
	always_ff @(posedge sysClk)
	begin
		if (wrHit && (regOfs == regTxData))
			txData <= sUsiWd[spiByteBit-1:0];
		if (rxValid)
			rxReg <= rxData;	// Byte from master engine
		sUsiRd <= rdMux;
	end

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (regOfs)
			regCtrl:
			begin
				rdMux[ctrlEnBit] = spiEn;
				rdMux[ctrlCsBit] = masterCs;
			end
			regDiv:    rdMux[divBit-1:0]     = spiDiv;
			regTxData: rdMux[spiByteBit-1:0] = txData;
			regRxData: rdMux[spiByteBit-1:0] = rxReg;
			regStatus:
			begin
				rdMux[statBusyBit]   = busy;
				rdMux[statMasterBit] = masterMode;
			end
			default:   rdMux = '0;	// Unmapped offset reads zero
		endcase
	end

endmodule

`default_nettype wire

// File: hw/spiBlock.sv
// SPI block top level, register file joined to the SPI unit
`default_nettype none
`timescale 1ns/1ps

module spiBlock (
	inout  wire                   spiSck,
	inout  wire                   spiMosi,
	inout  wire                   spiMiso,
	inout  wire                   spiCs,
	input  wire                   mSSel,	// Pulled up outside, master by default
	// Register bus slave side
	input  wire spiPkg::usiDataT  sUsiWd,
	input  wire spiPkg::usiAdrsT  sUsiAdrs,
	input  wire                   sUsiWCke,
	input  wire                   sUsiRCke,
	output spiPkg::usiDataT       sUsiRd,
	output logic                  sUsiREd,
	// Register bus master side
	output spiPkg::usiDataT       mUsiWd,
	output spiPkg::usiAdrsT       mUsiAdrs,
	output logic                  mUsiWEd,
	output logic                  mUsiMonopoly,
	output logic                  spiIntr,
	input  wire                   sysClk,
	input  wire                   rstN
);

	import spiPkg::*;

	// ----------------------------------------
	// Register file to unit
	// ----------------------------------------
	logic    spiEn, masterCs, txStart;
	spiDivT  spiDiv;
	spiByteT txData;
	spiByteT rxData;
	logic    rxValid, busy, masterMode;

	spiCsr u_spiCsr (
		.sUsiWd     (sUsiWd),
		.sUsiAdrs   (sUsiAdrs),
		.sUsiWCke   (sUsiWCke),
		.sUsiRCke   (sUsiRCke),
		.sUsiRd     (sUsiRd),
		.sUsiREd    (sUsiREd),
		.spiEn      (spiEn),
		.masterCs   (masterCs),
		.spiDiv     (spiDiv),
		.txData     (txData),
		.txStart    (txStart),
		.rxData     (rxData),
		.rxValid    (rxValid),
		.busy       (busy),
		.masterMode (masterMode),
		.sysClk     (sysClk),
		.rstN       (rstN)
	);

	spiUnit u_spiUnit (
		.spiSck       (spiSck),
		.spiMosi      (spiMosi),
		.spiMiso      (spiMiso),
		.spiCs        (spiCs),
		.mSSel        (mSSel),
		.spiEn        (spiEn),
		.masterCs     (masterCs),
		.spiDiv       (spiDiv),
		.txData       (txData),
		.txStart      (txStart),
		.rxData       (rxData),
		.rxValid      (rxValid),
		.busy         (busy),
		.masterMode   (masterMode),
		.mUsiWd       (mUsiWd),
		.mUsiAdrs     (mUsiAdrs),
		.mUsiWEd      (mUsiWEd),
		.mUsiMonopoly (mUsiMonopoly),
		.spiIntr      (spiIntr),
		.sysClk       (sysClk),
		.rstN         (rstN)
	);

endmodule

`default_nettype wire

// File: verification/spiTbTasks.svh
// SPI testbench tasks for register bus access, SPI pin models and result compares
`ifndef SPI_TB_TASKS_SVH
`define SPI_TB_TASKS_SVH

// ----------------------------------------
// Register bus access
// ----------------------------------------
function automatic usiAdrsT regAdrs(input logic [7:0] ofs);
	return {blockAdrsMap, ofs};	// This block's upper byte
endfunction

task automatic busWrite(input usiAdrsT adrs, input usiDataT data);
	sUsiAdrs <= adrs;
	sUsiWd   <= data;
	sUsiWCke <= 1'b1;
	@(posedge sysClk);
	sUsiWCke <= 1'b0;
endtask

// Read data and its valid taken one cycle after the strobe
task automatic busRead(input usiAdrsT adrs, output usiDataT data, output logic ed);
	sUsiAdrs <= adrs;
	sUsiRCke <= 1'b1;
	@(posedge sysClk);
	sUsiRCke <= 1'b0;
	@(posedge sysClk);
	data = sUsiRd;
	ed   = sUsiREd;
endtask

task automatic waitIntr(input int startCnt);
	int cycles;
	cycles = 0;
	while (intrCnt == startCnt && cycles < intrWaitMax)
	begin
		@(posedge sysClk);
		cycles++;
	end
	if (intrCnt == startCnt)
	begin
		$display("spiIntr did not arrive within %0d cycles at %0t", intrWaitMax, $time);
		errCount++;
	end
endtask

// ----------------------------------------
// SPI pin models
// ----------------------------------------
// Mode 0 slave that changes miso on falling SCK
task automatic spiSlaveModel(input spiByteT reply, output spiByteT got);
	spiByteT outSh;
	spiByteT inSh;
	int      i;
	outSh  = reply;
	inSh   = '0;
	tbMiso <= outSh[7];	// First bit before the first edge
	for (i = 0; i < 8; i++)
	begin
		@(posedge spiSck);
		compareBit("spiCs", spiCs, 1'b0);	// Selected for the whole byte
		inSh = {inSh[6:0], spiMosi};
		@(negedge spiSck);
		outSh  = {outSh[6:0], 1'b0};
		tbMiso <= outSh[7];
	end
	got = inSh;
endtask

// Mode 0 master with a 6-cycle half-period and cs left to the caller
task automatic spiMasterDrive(input spiByteT txB, output spiByteT rxB);
	int i;
	for (i = 7; i >= 0; i--)
	begin
		tbMosi <= txB[i];
		repeat (6) @(posedge sysClk);
		rxB[i] = spiMiso;	// Stable since the last falling edge
		tbSck <= 1'b1;
		repeat (6) @(posedge sysClk);
		tbSck <= 1'b0;
	end
endtask

// ----------------------------------------
// Compares and per-test report
// ----------------------------------------
task automatic compareByte(input string name, input spiByteT got, input spiByteT exp);
	checkCount++;
	if (got !== exp)
	begin
		$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
		errCount++;
	end
endtask

task automatic compareWord(input string name, input usiDataT got, input usiDataT exp);
	checkCount++;
	if (got !== exp)
	begin
		$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
		errCount++;
	end
endtask

task automatic compareAdrs(input string name, input usiAdrsT got, input usiAdrsT exp);
	checkCount++;
	if (got !== exp)
	begin
		$display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
		errCount++;
	end
endtask

task automatic compareBit(input string name, input logic got, input logic exp);
	checkCount++;
	if (got !== exp)
	begin
		$display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
		errCount++;
	end
endtask

task automatic reportTest(input string name);
	$display("Test %s finished with %0d error(s)", name, errCount - testErrBase);
	testErrBase = errCount;
	testCount++;
endtask

`endif

// File: verification/spiBlockTb.sv
// SPI block testbench, directed tests in master and slave mode
`default_nettype none
`timescale 1ns/1ps

module spiBlockTb;

	import spiPkg::*;

	localparam int clkPeriod      = 20;
	localparam int maxDiv         = 5;				// Largest divider used
	localparam int byteCycles     = 16 * (maxDiv + 1);	// One byte at maxDiv
	localparam int intrWaitMax    = 2 * byteCycles;
	localparam int testBytes      = 13;				// Bytes plus idle windows
	localparam int overheadCycles = 200;			// Resets and bus accesses
	localparam int watchdogCycles = (testBytes * byteCycles + overheadCycles) * 12 / 10;

	logic    sysClk;
	logic    rstN     = 1'b0;
	logic    mSSel    = 1'b1;	// Master at start
	usiDataT sUsiWd   = '0;
	usiAdrsT sUsiAdrs = '0;
	logic    sUsiWCke = 1'b0;
	logic    sUsiRCke = 1'b0;
	usiDataT sUsiRd, mUsiWd;
	usiAdrsT mUsiAdrs;
	logic    sUsiREd, mUsiWEd, mUsiMonopoly, spiIntr;
	wire     spiSck, spiMosi, spiMiso, spiCs;

	// Pin models
	logic tbSck  = 1'b0;
	logic tbMosi = 1'b0;
	logic tbCs   = 1'b1;
	logic tbMiso = 1'b0;

	int      seed        = 3;
	int      errCount    = 0;
	int      checkCount  = 0;
	int      testCount   = 0;
	int      testErrBase = 0;
	int      intrCnt     = 0;	// spiIntr pulses seen
	int      sckRises    = 0;
	usiDataT wrData[$];		// Slave mode bus writes
	usiAdrsT wrAdrs[$];

	`include "spiTbTasks.svh"

	spiBlock u_spiBlock (
		.spiSck (spiSck), .spiMosi (spiMosi), .spiMiso (spiMiso), .spiCs (spiCs),
		.mSSel (mSSel), .sUsiWd (sUsiWd), .sUsiAdrs (sUsiAdrs),
		.sUsiWCke (sUsiWCke), .sUsiRCke (sUsiRCke), .sUsiRd (sUsiRd), .sUsiREd (sUsiREd),
		.mUsiWd (mUsiWd), .mUsiAdrs (mUsiAdrs), .mUsiWEd (mUsiWEd),
		.mUsiMonopoly (mUsiMonopoly), .spiIntr (spiIntr), .sysClk (sysClk), .rstN (rstN)
	);

	pullup (spiSck);
	pullup (spiMosi);
	pullup (spiMiso);
	pullup (spiCs);

	assign spiSck  = mSSel ? 1'bz : tbSck;	// External master in slave mode
	assign spiMosi = mSSel ? 1'bz : tbMosi;
	assign spiCs   = mSSel ? 1'bz : tbCs;
	assign spiMiso = mSSel ? tbMiso : 1'bz;	// External slave in master mode

	initial
	begin
		sysClk = 1'b0;
		forever #(clkPeriod / 2) sysClk = ~sysClk;
	end

	// ----------------------------------------
	// Monitors, sampled mid-cycle
	// ----------------------------------------
	always @(negedge sysClk)
	begin
		if (spiIntr === 1'b1)
			intrCnt++;
		if (mUsiWEd === 1'b1)
		begin
			wrData.push_back(mUsiWd);
			wrAdrs.push_back(mUsiAdrs);
		end
	end

	always @(posedge spiSck)
		sckRises++;

	// Reset for 5 cycles, mode pin switched while pins are released
	task automatic applyReset(input logic modeSel);
		rstN <= 1'b0;
		repeat (2) @(posedge sysClk);
		mSSel <= modeSel;
		repeat (3) @(posedge sysClk);
		rstN <= 1'b1;
		@(posedge sysClk);	// Mode latched here
	endtask

	task automatic resetState();
		usiDataT rd;
		logic    ed;
		compareBit("sUsiREd", sUsiREd, 1'b0);
		compareBit("mUsiWEd", mUsiWEd, 1'b0);
		compareBit("spiIntr", spiIntr, 1'b0);
		compareBit("mUsiMonopoly", mUsiMonopoly, 1'b0);
		busRead(regAdrs(regStatus), rd, ed);
		compareBit("status busy", rd[statBusyBit], 1'b0);
		compareBit("status master", rd[statMasterBit], 1'b1);
		reportTest("reset state");
	endtask

	task automatic registerAccess();
		usiDataT rd;
		logic    ed;
		busWrite(regAdrs(regDiv), 32'h0000_1234);
		busRead(regAdrs(regDiv), rd, ed);
		compareBit("sUsiREd", ed, 1'b1);
		compareWord("regDiv", rd, 32'h0000_1234);
		busWrite(regAdrs(regCtrl), 32'h3);	// Enable, cs high
		busRead(regAdrs(regCtrl), rd, ed);
		compareWord("regCtrl", rd, 32'h3);
		busWrite({8'h05, regDiv}, 32'h0000_BEEF);	// Other block
		busRead(regAdrs(regDiv), rd, ed);
		compareWord("regDiv", rd, 32'h0000_1234);
		busRead({8'h05, regDiv}, rd, ed);
		compareBit("sUsiREd", ed, 1'b0);
		reportTest("register access");
	endtask

	task automatic masterTransfer();
		spiByteT txB, reply, got;
		usiDataT rd;
		logic    ed;
		int      i, startCnt;
		busWrite(regAdrs(regDiv), 32'd1);
		busWrite(regAdrs(regCtrl), 32'h1);	// Enable, cs low
		for (i = 0; i < 4; i++)
		begin
			txB      = spiByteT'($random(seed));
			reply    = spiByteT'($random(seed));
			startCnt = intrCnt;
			fork
				spiSlaveModel(reply, got);
				begin
					busWrite(regAdrs(regTxData), usiDataT'(txB));
					waitIntr(startCnt);
				end
			join
			busRead(regAdrs(regRxData), rd, ed);
			compareByte("spiMosi", got, txB);
			compareByte("regRxData", rd[7:0], reply);
			repeat (2) @(posedge sysClk);
			compareWord("spiIntr count", intrCnt - startCnt, 1);
		end
		busWrite(regAdrs(regCtrl), 32'h3);	// Deselect
		reportTest("master transfer");
	endtask

	// SCK high phase measured in clock cycles
	task automatic dividerCheck(input spiDivT div);
		int highCycles, waitCycles, startCnt;
		highCycles = 0;
		waitCycles = 0;
		startCnt   = intrCnt;
		busWrite(regAdrs(regDiv), usiDataT'(div));
		busWrite(regAdrs(regTxData), 32'h5A);
		while (spiSck !== 1'b1 && waitCycles < intrWaitMax)
		begin
			@(posedge sysClk);
			waitCycles++;
		end
		while (spiSck === 1'b1 && highCycles < intrWaitMax)
		begin
			@(posedge sysClk);
			highCycles++;
		end
		compareWord("spiSck high cycles", highCycles, div + 1);
		waitIntr(startCnt);
	endtask

	task automatic dividerTiming();
		dividerCheck(16'd2);
		dividerCheck(16'd5);
		reportTest("divider timing");
	endtask

	task automatic droppedStarts();
		int startCnt, edgeCnt;
		startCnt = intrCnt;
		busWrite(regAdrs(regTxData), 32'hC3);
		busWrite(regAdrs(regTxData), 32'h3C);	// Arrives while busy
		waitIntr(startCnt);
		repeat (byteCycles + 20) @(posedge sysClk);
		compareWord("spiIntr count", intrCnt - startCnt, 1);
		busWrite(regAdrs(regCtrl), 32'h2);	// Enable off
		edgeCnt  = sckRises;
		startCnt = intrCnt;
		busWrite(regAdrs(regTxData), 32'hA5);
		repeat (byteCycles) @(posedge sysClk);
		compareWord("spiSck rising edges", sckRises - edgeCnt, 0);
		compareWord("spiIntr count", intrCnt - startCnt, 0);
		reportTest("dropped starts");
	endtask

	task automatic slaveReceive();
		spiByteT sent[3];
		spiByteT misoGot[3];
		spiByteT misoExp;
		int      i;
		applyReset(1'b0);
		wrData.delete();
		wrAdrs.delete();
		repeat (4) @(posedge sysClk);
		compareBit("mUsiMonopoly", mUsiMonopoly, 1'b0);
		tbCs <= 1'b0;
		for (i = 0; i < 3; i++)
		begin
			sent[i] = spiByteT'($random(seed));
			spiMasterDrive(sent[i], misoGot[i]);
			compareBit("mUsiMonopoly", mUsiMonopoly, 1'b1);
		end
		repeat (8) @(posedge sysClk);	// Last bus write lands
		tbCs <= 1'b1;
		repeat (4) @(posedge sysClk);
		compareBit("mUsiMonopoly", mUsiMonopoly, 1'b0);
		compareWord("mUsiWEd count", wrData.size(), 3);
		for (i = 0; i < 3; i++)
		begin
			misoExp = (i == 0) ? 8'h00 : sent[i-1];	// Echo of previous byte
			compareByte("spiMiso", misoGot[i], misoExp);
			compareWord("mUsiWd", wrData[i], usiDataT'(sent[i]));
			compareAdrs("mUsiAdrs", wrAdrs[i], usiAdrsT'(slaveWrBase + i));
		end
		reportTest("slave receive");
	endtask

	// ----------------------------------------
	// Test sequence and watchdog
	// ----------------------------------------
	initial
	begin
		applyReset(1'b1);
		resetState();
		registerAccess();
		masterTransfer();
		dividerTiming();
		droppedStarts();
		slaveReceive();
		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge sysClk);
		$display("TIMEOUT: run did not finish within %0d clock cycles", watchdogCycles);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verification
hw/spiPkg.sv
hw/spiClockGen.sv
hw/spiMasterEngine.sv
hw/spiSlaveEngine.sv
hw/spiUnit.sv
hw/spiCsr.sv
hw/spiBlock.sv
verification/spiBlockTb.sv

// File: Bender.yml
package:
  name: spiBlock

sources:
  - files:
      - hw/spiPkg.sv
      - hw/spiClockGen.sv
      - hw/spiMasterEngine.sv
      - hw/spiSlaveEngine.sv
      - hw/spiUnit.sv
      - hw/spiCsr.sv
      - hw/spiBlock.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/spiBlockTb.sv
